/* files.f */
+incdir+.
freecellPkg.sv
moveChecker.sv
moveSequencer.sv
boardState.sv
freecellTop.sv
freecell_checker.sv
freecellTb.sv

/* freecellTb.sv */
`include "freecell_config.svh"

module freecellTb;
	import freecellPkg::*;

	localparam int ackTimeout = 20; // edges allowed per handshake phase

	// game 8321 top to bottom per column, code is suit * 16 + rank, 0 pads
	localparam logic [`CARD_BITS-1:0] dealCols [`NUM_COLUMNS][7] = '{
		'{36, 27, 26, 22, 35, 17, 1},
		'{37, 42, 8, 52, 6, 13, 2},
		'{43, 55, 57, 54, 50, 45, 49},
		'{4, 33, 60, 53, 39, 9, 40},
		'{28, 11, 44, 38, 18, 41, 0},
		'{21, 29, 51, 25, 3, 34, 0},
		'{5, 19, 12, 23, 61, 58, 0},
		'{59, 20, 10, 56, 7, 24, 0}
	};

	// {verdict, source, dest}
	localparam logic [8:0] directed [10] = '{
		9'h138, // 8 of suit 2 to free cell 0
		9'h183, // and back onto the 9 of suit 0
		9'h174, // red 8 onto black 9
		9'h0C0, // home as source
		9'h090, // empty free cell
		9'h138, // refill free cell 0
		9'h058, // occupied free cell
		9'h025, // same colour ace on two
		9'h01C, // two before its ace
		9'h183  // board still as before
	};

	logic clock;
	logic rstN;
	logic moveReq;
	moveT move;
	logic moveAck;
	logic accepted;
	logic win;

	// reference board
	logic [`CARD_BITS-1:0] colCards [`NUM_COLUMNS][32];
	int colLen [`NUM_COLUMNS];
	cardT freeCell [`NUM_FREE];
	logic [`RANK_BITS-1:0] homeRank [`NUM_FREE];

	logic [15:0] lfsr;
	int errors;
	int testStart;
	int testsPassed;
	int testsFailed;

	freecellTop freecellTop_i (
		.clock(clock),
		.rstN(rstN),
		.moveReq(moveReq),
		.move(move),
		.moveAck(moveAck),
		.accepted(accepted),
		.win(win)
	);

	initial
		clock = 1'b0;
	always #20 clock = ~clock;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[15]};
			lfsr = lfsrNext(lfsr); // one step per bit
		end
	endtask

	function automatic cardT columnTail(input int c);
		if (colLen[c] == 0)
			return '0;
		return cardT'(colCards[c][colLen[c] - 1]);
	endfunction

	function automatic cardT cardAt(input locT l);
		if (!l[3])
			return columnTail(l[2:0]);
		if (l[3:2] == 2'b10)
			return freeCell[l[1:0]];
		return '0; // home never gives a card
	endfunction

	function automatic logic modelWin();
		for (int s = 0; s < `NUM_FREE; s++)
			if (homeRank[s] != `RANK_KING)
				return 1'b0;
		return 1'b1;
	endfunction

	// FreeCell rules on the reference board, applied when legal
	task automatic modelMove(input moveT m, output logic ok);
		cardT card;
		cardT dstTail;
		int dc;
		card = cardAt(m.source);
		dc = m.dest[2:0];
		ok = 1'b0;
		if (card == '0)
			return;
		if (m.dest[3:2] == 2'b10)
		begin
			ok = !m.source[3] && freeCell[m.dest[1:0]] == '0; // free to free stays put
			if (ok)
				freeCell[m.dest[1:0]] = card;
		end
		else if (m.dest[3:2] == 2'b11)
		begin
			ok = int'(card.rank) == int'(homeRank[card.suit]) + 1;
			if (ok)
				homeRank[card.suit] = card.rank;
		end
		else
		begin
			dstTail = columnTail(dc);
			ok = dstTail == '0 || (dstTail.suit[1] != card.suit[1] &&
				int'(dstTail.rank) == int'(card.rank) + 1);
			if (ok)
			begin
				colCards[dc][colLen[dc]] = card;
				colLen[dc]++;
			end
		end
		if (ok && !m.source[3])
			colLen[m.source[2:0]]--;
		else if (ok)
			freeCell[m.source[1:0]] = '0;
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string what);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic checkBoard();
		boardViewT expected;
		for (int c = 0; c < `NUM_COLUMNS; c++)
			expected.tails[c] = columnTail(c);
		for (int i = 0; i < `NUM_FREE; i++)
		begin
			expected.free[i] = freeCell[i];
			expected.home[i] = homeRank[i];
		end
		assert (freecellTop_i.view === expected)
		else
		begin
			$display("CHECK FAILED at %0t: board %h, expected %h", $time,
				freecellTop_i.view, expected);
			errors++;
		end
		checkBit(win, modelWin(), "win");
	endtask

	// one full four-phase handshake, request held extraHold cycles past ack
	task automatic sendMove(input moveT m, input int extraHold);
		int edges;
		logic ok;
		@(posedge clock);
		#2;
		move = m;
		moveReq = 1'b1;
		modelMove(m, ok);
		edges = 0;
		while (!moveAck && edges < ackTimeout)
		begin
			@(posedge clock);
			edges++;
			@(negedge clock); // sample away from the edge
		end
		if (!moveAck)
		begin
			$display("timeout: moveAck never rose for move %h at %0t", m, $time);
			errors++;
		end
		else
		begin
			assert (edges == 2)
			else
			begin
				$display("CHECK FAILED at %0t: moveAck after %0d edges, expected 2", $time, edges);
				errors++;
			end
			checkBit(accepted, ok, $sformatf("accepted for move %h", m));
			checkBoard();
		end
		repeat (extraHold)
		begin
			@(negedge clock);
			checkBit(moveAck, 1'b1, "moveAck while moveReq held");
		end
		if (extraHold > 0)
			checkBoard(); // still one move only
		@(posedge clock);
		#2;
		moveReq = 1'b0;
		edges = 0;
		while (moveAck && edges < ackTimeout)
		begin
			@(posedge clock);
			edges++;
			@(negedge clock);
		end
		if (moveAck)
		begin
			$display("timeout: moveAck stayed high after moveReq fell at %0t", $time);
			errors++;
		end
	endtask

	task automatic runDirected(input int first, input int last);
		for (int i = first; i <= last; i++)
		begin
			sendMove(moveT'(directed[i][7:0]), 0);
			checkBit(accepted, directed[i][8], $sformatf("directed move %h", directed[i][7:0]));
		end
	endtask

	task endTest(input string name);
		if (errors == testStart)
		begin
			testsPassed++;
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - testStart);
		end
		testStart = errors;
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] holdBits;
		cardT card;
		errors = 0;
		testStart = 0;
		testsPassed = 0;
		testsFailed = 0;
		lfsr = 16'd6808;
		rstN = 1'b0;
		moveReq = 1'b0;
		move = '0;
		for (int c = 0; c < `NUM_COLUMNS; c++)
		begin
			colLen[c] = 0;
			for (int k = 0; k < 7; k++)
				if (dealCols[c][k] != 0)
				begin
					colCards[c][colLen[c]] = dealCols[c][k];
					colLen[c]++;
				end
		end
		for (int i = 0; i < `NUM_FREE; i++)
		begin
			freeCell[i] = '0;
			homeRank[i] = '0;
		end

		repeat (8)
		begin
			@(posedge clock);
			#1;
			checkBit(moveAck, 1'b0, "moveAck in reset");
			checkBit(accepted, 1'b0, "accepted in reset");
			checkBit(win, 1'b0, "win in reset");
		end
		#1;
		rstN = 1'b1;
		@(negedge clock);
		checkBit(moveAck, 1'b0, "moveAck after reset");
		checkBit(accepted, 1'b0, "accepted after reset");
		checkBoard(); // the deal as loaded
		runDirected(0, 0);
		endTest("reset and first handshake");

		runDirected(1, 2);
		endTest("directed legal moves");

		runDirected(3, 9);
		endTest("directed illegal moves");

		repeat (400)
		begin
			takeBits(8, r);
			sendMove(moveT'(r[7:0]), 0);
		end
		endTest("random moves");

		// codes 0..7 are columns, 8..11 free cells
		for (int p = 0; p < 4; p++)
			for (int s = 0; s < 12; s++)
			begin
				card = cardAt(locT'(s));
				if (card != '0 && card.rank <= 2)
					sendMove(moveT'({locT'(s), 4'hC}), 0);
			end
		endTest("aces and twos home");

		repeat (30)
		begin
			takeBits(8, r);
			takeBits(3, holdBits);
			sendMove(moveT'(r[7:0]), int'(holdBits[2:0]) + 1);
		end
		endTest("slow requester");

		$display("tests passed: %0d, failed: %0d, assertion failures: %0d", testsPassed,
			testsFailed, freecellTop_i.freecellChecker_i.failures);
		if (testsFailed == 0 && freecellTop_i.freecellChecker_i.failures == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* freecell_checker.sv */
module freecellChecker (
	input logic clock,
	input logic rstN,
	input logic moveReq,
	input logic moveAck,
	input logic accepted,
	input logic win,
	input logic applyEn
);

	int failures = 0; // failed assertions so far

	// ack only ever answers a live request
	ackNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(moveAck) |-> moveReq)
		else
		begin
			$error("moveAck rose while moveReq was low");
			failures++;
		end

	ackHolds: assert property (@(posedge clock) disable iff (!rstN)
		moveAck && moveReq |=> moveAck) // no drop before the requester lets go
		else
		begin
			$error("moveAck fell while moveReq was still high");
			failures++;
		end

	// one board write per request
	applyOnce: assert property (@(posedge clock) disable iff (!rstN)
		applyEn |=> !applyEn)
		else
		begin
			$error("applyEn high for more than one cycle");
			failures++;
		end

	resetQuiet: assert property (@(posedge clock)
		!rstN |-> !moveAck && !accepted && !win)
		else
		begin
			$error("outputs not low during reset");
			failures++;
		end

endmodule

bind freecellTop freecellChecker freecellChecker_i (.*);

/* freecellTop.sv */
`include "freecell_config.svh"

module freecellTop (
	input logic clock,
	input logic rstN,
	input logic moveReq,
	input freecellPkg::moveT move,
	output logic moveAck,
	output logic accepted,
	output logic win
);
	import freecellPkg::*;

	moveT heldMove; // latched request
	moveKindE kind; // checker verdict
	boardViewT view;
	logic applyEn; // board write strobe

	moveSequencer moveSequencer_i (
		.clock(clock),
		.rstN(rstN),
		.moveReq(moveReq),
		.move(move),
		.kind(kind),
		.heldMove(heldMove),
		.applyEn(applyEn),
		.moveAck(moveAck),
		.accepted(accepted)
	);

	moveChecker moveChecker_i (
		.heldMove(heldMove),
		.view(view),
		.kind(kind)
	);

	boardState boardState_i (
		.clock(clock),
		.rstN(rstN),
		.applyEn(applyEn),
		.heldMove(heldMove),
		.kind(kind),
		.view(view)
	);

	// game over once every suit is home up to king
	always_comb
	begin
		win = 1'b1;
		for (int i = 0; i < `NUM_FREE; i++)
			if (view.home[i] != `RANK_BITS'(`RANK_KING))
				win = 1'b0;
	end

endmodule

/* boardState.sv */
`include "freecell_config.svh"

module boardState (
	input logic clock,
	input logic rstN,
	input logic applyEn,
	input freecellPkg::moveT heldMove,
	input freecellPkg::moveKindE kind,
	output freecellPkg::boardViewT view
);
	import freecellPkg::*;

	// game 8321, predecessor of each card code in its column
	localparam logic [`CARD_BITS-1:0] dealPrev [`NUM_CARDS] = '{
		 0, 17, 13, 25,  0,  0, 52, 56, // codes 0..7
		42, 39, 20, 28, 19,  6,  0,  0, // 8..15
		 0, 35, 38,  5, 59,  0, 26, 12, // 16..23
		 7, 51, 27, 36,  0, 21,  0,  0, // 24..31
		 0,  4,  3, 22,  0,  0, 44, 53, // 32..39
		 9, 18, 37,  0, 11, 50,  0,  0, // 40..47
		 0, 45, 54, 29,  8, 60, 57, 43, // 48..55
		10, 55, 61,  0, 33, 23,  0,  0  // 56..63
	};

	// bottom card of each column in the deal
	localparam logic [`CARD_BITS-1:0] dealTail [`NUM_COLUMNS] = '{
		1, 2, 49, 40, 41, 34, 58, 24
	};

	logic [`CARD_BITS-1:0] prev [`NUM_CARDS]; // linked lists, card -> card above
	cardT [`NUM_COLUMNS-1:0] tailQ;
	cardT [`NUM_FREE-1:0] freeQ;
	logic [`NUM_FREE-1:0][`RANK_BITS-1:0] homeQ;

	logic [2:0] srcCol; // source column
	logic [2:0] dstCol;
	logic [1:0] srcCell; // source free cell
	logic [1:0] dstCell;
	cardT srcTail; // card leaving a column
	cardT srcFree; // card leaving a free cell

	assign srcCol = heldMove.source[2:0];
	assign dstCol = heldMove.dest[2:0];
	assign srcCell = heldMove.source[1:0];
	assign dstCell = heldMove.dest[1:0];
	assign srcTail = tailQ[srcCol];
	assign srcFree = freeQ[srcCell];

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			// reload the deal
			for (int i = 0; i < `NUM_CARDS; i++)
				prev[i] <= dealPrev[i];
			for (int i = 0; i < `NUM_COLUMNS; i++)
				tailQ[i] <= dealTail[i];
			freeQ <= '0; // all free cells empty
			homeQ <= '0; // nothing home yet
		end
		else if (applyEn)
		begin
			case (kind)
				tabToFree:
				begin
					freeQ[dstCell] <= srcTail;
					tailQ[srcCol] <= prev[srcTail]; // uncover card above
				end
				tabToHome:
				begin
					homeQ[srcTail.suit] <= srcTail.rank;
					tailQ[srcCol] <= prev[srcTail];
				end
				tabToTab:
				begin
					// hook source tail under destination tail
					prev[srcTail] <= tailQ[dstCol];
					tailQ[dstCol] <= srcTail;
					tailQ[srcCol] <= prev[srcTail]; // old link, read before update
				end
				freeToHome:
				begin
					homeQ[srcFree.suit] <= srcFree.rank;
					freeQ[srcCell] <= '0;
				end
				freeToTab:
				begin
					prev[srcFree] <= tailQ[dstCol]; // empty column links to 0
					tailQ[dstCol] <= srcFree;
					freeQ[srcCell] <= '0;
				end
				default:
				begin
					// reject, board untouched
				end
			endcase
		end
	end

	// view for the checker and for win
	assign view.tails = tailQ;
	assign view.free = freeQ;
	assign view.home = homeQ;

endmodule

/* moveSequencer.sv */
`include "freecell_config.svh"

module moveSequencer (
	input logic clock,
	input logic rstN,
	input logic moveReq,
	input freecellPkg::moveT move,
	input freecellPkg::moveKindE kind,
	output freecellPkg::moveT heldMove,
	output logic applyEn,
	output logic moveAck,
	output logic accepted
);
	import freecellPkg::*;

	seqStateE state, nextState;

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
				if (moveReq)
					nextState = apply; // move captured this edge
			apply:
				nextState = answer; // board written this edge
			answer:
				if (!moveReq)
					nextState = releaseAck; // requester withdrew
			releaseAck:
				nextState = idle;
			default:
				nextState = idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= idle;
		else
			state <= nextState;
	end

	// hold the move steady for checker and board
	always_ff @(posedge clock)
	begin
		if (state == idle && moveReq)
			heldMove <= move;
	end

	// verdict kept until the next answer
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			accepted <= 1'b0;
		else if (applyEn)
			accepted <= kind != reject;
	end

	assign applyEn = state == apply; // one cycle per request
	assign moveAck = state == answer;

endmodule

/* moveChecker.sv */
`include "freecell_config.svh"

module moveChecker (
	input freecellPkg::moveT heldMove,
	input freecellPkg::boardViewT view,
	output freecellPkg::moveKindE kind
);
	import freecellPkg::*;

	logic srcIsTab, srcIsFree; // source class
	logic dstIsTab, dstIsFree, dstIsHome;
	cardT srcCard; // card that would move
	cardT dstTail; // card it would land on
	logic [`RANK_BITS-1:0] homeRank; // home pile of the card's suit
	logic freeDstEmpty;
	logic homeOk;
	logic stackOk;

	assign srcIsTab = !heldMove.source[3];
	assign srcIsFree = heldMove.source[3:2] == 2'b10;
	assign dstIsTab = !heldMove.dest[3];
	assign dstIsFree = heldMove.dest[3:2] == 2'b10;
	assign dstIsHome = heldMove.dest[3:2] == 2'b11; // low bits ignored

	// a home source picks a free cell here, but is never accepted below
	assign srcCard = srcIsTab ? view.tails[heldMove.source[2:0]]
		: view.free[heldMove.source[1:0]];
	assign dstTail = view.tails[heldMove.dest[2:0]];
	assign homeRank = view.home[srcCard.suit];

	assign freeDstEmpty = view.free[heldMove.dest[1:0]] == '0;
	assign homeOk = srcCard.rank == homeRank + `RANK_BITS'(1); // next rank of suit

	// empty column, or opposite colour one rank up
	assign stackOk = (dstTail == '0) ||
		((dstTail.suit[1] != srcCard.suit[1]) &&
		(dstTail.rank == srcCard.rank + `RANK_BITS'(1)));

	always_comb
	begin
		kind = reject;
		if (srcCard != '0)
		begin
			if (srcIsTab)
			begin
				if (dstIsFree)
				begin
					if (freeDstEmpty)
						kind = tabToFree;
				end
				else if (dstIsHome)
				begin
					if (homeOk)
						kind = tabToHome;
				end
				else if (stackOk) // same column fails on colour
					kind = tabToTab;
			end
			else if (srcIsFree)
			begin
				if (dstIsHome && homeOk)
					kind = freeToHome;
				else if (dstIsTab && stackOk)
					kind = freeToTab;
				// free to free stays reject
			end
		end
	end

endmodule

/* freecellPkg.sv */
`include "freecell_config.svh"

package freecellPkg;

	// high suit bit doubles as the colour
	typedef struct packed {
		logic [`SUIT_BITS-1:0] suit;
		logic [`RANK_BITS-1:0] rank; // 1 = ace .. 13 = king
	} cardT;

	// 0ccc column, 10ff free cell, 11xx home
	typedef logic [`LOC_BITS-1:0] locT;

	typedef struct packed {
		locT source;
		locT dest;
	} moveT;

	// what the checker decided to do with a move
	typedef enum logic [2:0] {
		tabToFree,
		tabToHome,
		tabToTab,
		freeToHome,
		freeToTab,
		reject
	} moveKindE;

	// everything the checker needs to see of the board
	typedef struct packed {
		cardT [`NUM_COLUMNS-1:0] tails; // bottom card of each column
		cardT [`NUM_FREE-1:0] free;
		logic [`NUM_FREE-1:0][`RANK_BITS-1:0] home; // top rank per suit
	} boardViewT;

	// handshake sequencer
	typedef enum logic [1:0] {
		idle,
		apply,
		answer,
		releaseAck // one edge back to idle once the ack drops
	} seqStateE;

endpackage

/* freecell_config.svh */
`ifndef FREECELL_CONFIG_SVH
`define FREECELL_CONFIG_SVH

// tableau and cell geometry
`define NUM_COLUMNS 8
`define NUM_FREE 4 // free cells, also home piles

// card code layout
`define SUIT_BITS 2
`define RANK_BITS 4
`define CARD_BITS 6 // suit and rank, 0 means no card
`define NUM_CARDS 64 // size of the predecessor table

// location code width for source and dest
`define LOC_BITS 4

// a home pile at king is complete
`define RANK_KING 13

`endif
